//--- daq_consts.svh
`ifndef DAQ_CONSTS_SVH
`define DAQ_CONSTS_SVH

// Host mailbox
`define MBOX_DEPTH 32        // Bytes
`define MBOX_AW    5         // Address bits for 32 bytes

// Sample and FIFO word widths
`define SAMPLE_W 16          // One ADC channel
`define WORD_W   32          // Two samples per word

// Event FIFO
`define FIFO_DEPTH 16        // Words

// Settling time after a reset
// Veto drops on the cycle after the counter hits this value
`define VETO_HOLD_CYCLES 450

// Upper half of every trailer word
`define TRAILER_TAG 16'hF0F0

// Mailbox command handshake
`define ACK_FLAG 8'h80       // ORed into the opcode on acknowledge
`define CMD_ADDR 0           // Command byte lives at address 0

`endif

//--- acq_pkg.sv
`include "daq_consts.svh"

package acq_pkg;

  // One channel sample, parallel from the ADC receiver
  typedef logic [`SAMPLE_W-1:0] adc_sample_t;

  typedef logic [`WORD_W-1:0] fifo_word_t;  // Packed word into the event FIFO

  // Packer output sequence
  // Each state names the word on word_data in that cycle
  typedef enum logic [1:0] {
    idle,          // No word out
    emit_low,      // Low channel pair
    emit_high,     // High channel pair
    emit_trailer   // Tag plus frame count
  } pack_state_e;

endpackage

//--- host_pkg.sv
`include "daq_consts.svh"

package host_pkg;

  typedef logic [`MBOX_AW-1:0] mbox_addr_t;  // Mailbox byte address
  typedef logic [7:0]          mbox_byte_t;  // Mailbox data

  // Opcodes written by the host into the command byte
  typedef enum logic [7:0] {
    cmd_nop   = 8'h00,  // Idle value
    cmd_reset = 8'h01,  // Restart the run
    cmd_stop  = 8'h02   // Halt data taking
  } cmd_opcode_e;

  // Control block states
  // Command side uses poll and ack_write
  // Run side uses settle, run and halted
  typedef enum logic [2:0] {
    poll,
    ack_write,
    settle,     // Veto held while front end settles
    run,        // Writes allowed
    halted      // Sticky veto until next reset
  } ctrl_state_e;

endpackage

//--- mailbox_ram.sv
`timescale 1ns/1ns
`include "daq_consts.svh"

module mailbox_ram (
  input  logic                 clk100M,
  // Port A, host side
  input  host_pkg::mbox_addr_t a_addr,
  input  logic                 a_wr_en,
  input  host_pkg::mbox_byte_t a_wdata,
  input  logic                 a_rd_en,
  output host_pkg::mbox_byte_t a_rdata,
  // Port B, control side
  input  host_pkg::mbox_addr_t b_addr,
  input  logic                 b_wr_en,
  input  host_pkg::mbox_byte_t b_wdata,
  output host_pkg::mbox_byte_t b_rdata
);

  host_pkg::mbox_byte_t mem [0:`MBOX_DEPTH-1];

  // Read-first on both ports
  // A write shows up on a read of the same byte one cycle later
  always_ff @(posedge clk100M) begin
    if (a_wr_en)
      mem[a_addr] <= a_wdata;
    if (b_wr_en)
      mem[b_addr] <= b_wdata;  // Port B last so it wins a clash
    if (a_rd_en)
      a_rdata <= mem[a_addr];  // Host data one cycle after rd_en
    b_rdata <= mem[b_addr];    // Control side polls every cycle
  end

  // Host and control block never write the same byte at once
  a_no_write_clash: assert property (
    @(posedge clk100M) !(a_wr_en && b_wr_en && (a_addr == b_addr))
  );

endmodule

//--- acq_control.sv
`timescale 1ns/1ns
`include "daq_consts.svh"

module acq_control (
  input  logic                 clk100M,
  input  logic                 rst_command,
  input  host_pkg::mbox_byte_t mbox_rdata,   // Command byte, one cycle late
  input  logic                 fifo_full,
  output host_pkg::mbox_addr_t mbox_addr,
  output logic                 mbox_wr_en,
  output host_pkg::mbox_byte_t mbox_wdata,
  output logic                 run_reset,    // One-cycle pulse
  output logic                 write_veto
);

  localparam int CNT_W = $clog2(`VETO_HOLD_CYCLES + 1);

  host_pkg::ctrl_state_e cmd_state;  // Poll or ack_write
  host_pkg::ctrl_state_e phase;      // Settle, run or halted
  logic                  stale_rd;   // Read in flight predates the ack
  logic [CNT_W-1:0]      veto_cnt;   // Settling timer
  logic                  do_reset;
  logic                  do_stop;

  assign mbox_addr = host_pkg::mbox_addr_t'(`CMD_ADDR);  // Only byte 0 watched

  // Opcode decode
  // Nop, unknown values and acked bytes fall through
  always_comb begin
    do_reset = 1'b0;
    do_stop  = 1'b0;
    if (cmd_state == host_pkg::poll && !stale_rd) begin
      do_reset = (mbox_rdata == host_pkg::cmd_reset);
      do_stop  = (mbox_rdata == host_pkg::cmd_stop);
    end
  end

  // Command handshake
  always_ff @(posedge clk100M) begin
    if (rst_command) begin
      cmd_state  <= host_pkg::poll;
      stale_rd   <= 1'b0;
      mbox_wr_en <= 1'b0;
      run_reset  <= 1'b0;
    end else begin
      mbox_wr_en <= 1'b0;
      run_reset  <= 1'b0;
      stale_rd   <= 1'b0;
      case (cmd_state)
        host_pkg::poll: begin
          if (do_reset || do_stop) begin
            cmd_state  <= host_pkg::ack_write;
            mbox_wr_en <= 1'b1;       // Ack goes out next cycle
            run_reset  <= do_reset;   // Same cycle as the ack write
          end
        end
        host_pkg::ack_write: begin
          cmd_state <= host_pkg::poll;
          // Port B read of this cycle still returns the raw opcode
          stale_rd  <= 1'b1;
        end
        default: cmd_state <= host_pkg::poll;
      endcase
    end
  end

  // Acknowledge byte
  always_ff @(posedge clk100M) begin
    if (do_reset || do_stop)
      mbox_wdata <= mbox_rdata | `ACK_FLAG;
  end

  // Run phase and write veto
  always_ff @(posedge clk100M) begin
    if (rst_command || do_reset) begin
      phase      <= host_pkg::settle;
      veto_cnt   <= '0;
      write_veto <= 1'b1;  // Held through settling
    end else if (do_stop) begin
      phase      <= host_pkg::halted;
      write_veto <= 1'b1;
    end else begin
      case (phase)
        host_pkg::settle: begin
          veto_cnt <= veto_cnt + 1'b1;
          if (veto_cnt == CNT_W'(`VETO_HOLD_CYCLES)) begin
            phase      <= host_pkg::run;
            write_veto <= 1'b0;  // 451 cycles after reset
          end
        end
        host_pkg::run: begin
          if (fifo_full) begin   // Overflow sticks until next reset
            phase      <= host_pkg::halted;
            write_veto <= 1'b1;
          end
        end
        default: write_veto <= 1'b1;  // Halted
      endcase
    end
  end

  // Run reset is a single pulse
  a_reset_pulse: assert property (
    @(posedge clk100M) disable iff (rst_command) run_reset |=> !run_reset
  );

  // Veto and ack write come up together with run reset
  a_reset_veto: assert property (
    @(posedge clk100M) disable iff (rst_command) run_reset |-> (write_veto && mbox_wr_en)
  );

endmodule

//--- frame_packer.sv
`timescale 1ns/1ns
`include "daq_consts.svh"

module frame_packer (
  input  logic                 clk100M,
  input  logic                 rst_command,
  input  logic                 run_reset,
  input  logic                 sample_strobe,  // Channels valid this cycle
  input  acq_pkg::adc_sample_t ch0,
  input  acq_pkg::adc_sample_t ch1,
  input  acq_pkg::adc_sample_t ch2,
  input  acq_pkg::adc_sample_t ch3,
  input  logic                 frame_mark,     // Level, falling edge ends a frame
  output logic                 word_valid,
  output acq_pkg::fifo_word_t  word_data
);

  acq_pkg::pack_state_e state;
  acq_pkg::pack_state_e state_nxt;
  acq_pkg::adc_sample_t ch2_q;      // High pair kept for the second word
  acq_pkg::adc_sample_t ch3_q;
  logic                 frame_q;
  logic                 frame_fall;
  logic                 trailer_pend;  // One trailer waiting behind a pair
  logic                 trailer_req;
  logic [15:0]          frame_cnt;
  logic [15:0]          cnt_next;

  assign frame_fall  = frame_q && !frame_mark;
  assign cnt_next    = frame_cnt + 16'(frame_fall);  // Counts the current edge
  assign trailer_req = trailer_pend || frame_fall;

  // Sample words first, trailer on the first free slot
  always_comb begin
    state_nxt = acq_pkg::idle;
    case (state)
      acq_pkg::emit_low:
        state_nxt = acq_pkg::emit_high;
      acq_pkg::emit_high:
        if (trailer_req)
          state_nxt = acq_pkg::emit_trailer;
      default: begin  // Idle or trailer just sent
        if (sample_strobe)
          state_nxt = acq_pkg::emit_low;
        else if (trailer_req)
          state_nxt = acq_pkg::emit_trailer;
      end
    endcase
  end

  always_ff @(posedge clk100M) begin
    if (rst_command)
      frame_q <= 1'b0;   // No false edge out of reset
    else
      frame_q <= frame_mark;
  end

  // Control state
  always_ff @(posedge clk100M) begin
    if (rst_command || run_reset) begin
      state        <= acq_pkg::idle;
      word_valid   <= 1'b0;
      trailer_pend <= 1'b0;
      frame_cnt    <= '0;  // Next trailer starts at 1
    end else begin
      state        <= state_nxt;
      word_valid   <= (state_nxt != acq_pkg::idle);
      frame_cnt    <= cnt_next;
      trailer_pend <= trailer_req && (state_nxt != acq_pkg::emit_trailer);
    end
  end

  // Payload
  always_ff @(posedge clk100M) begin
    if (state_nxt == acq_pkg::emit_low) begin
      ch2_q <= ch2;
      ch3_q <= ch3;
    end
    case (state_nxt)
      acq_pkg::emit_low:     word_data <= {ch1, ch0};
      acq_pkg::emit_high:    word_data <= {ch3_q, ch2_q};
      acq_pkg::emit_trailer: word_data <= {`TRAILER_TAG, cnt_next};
      default:               word_data <= word_data;  // Hold when idle
    endcase
  end

  // Two free cycles between strobes keep the pair intact
  a_strobe_gap: assert property (
    @(posedge clk100M) disable iff (rst_command)
      sample_strobe |=> !sample_strobe [*2]
  );

endmodule

//--- event_fifo.sv
`timescale 1ns/1ns
`include "daq_consts.svh"

module event_fifo (
  input  logic                clk100M,
  input  logic                rst_command,
  input  logic                run_reset,   // Flush
  input  logic                wr_en,
  input  acq_pkg::fifo_word_t wr_data,
  input  logic                write_veto,
  input  logic                rd_en,
  output acq_pkg::fifo_word_t rd_data,     // Valid the cycle after rd_en
  output logic                empty,
  output logic                full
);

  localparam int AW = $clog2(`FIFO_DEPTH);

  acq_pkg::fifo_word_t mem [0:`FIFO_DEPTH-1];
  logic [AW:0]         wr_ptr;  // Top bit is the wrap flag
  logic [AW:0]         rd_ptr;
  logic                wr_ok;
  logic                rd_ok;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // Vetoed or overflowing words are dropped here
  assign wr_ok = wr_en && !write_veto && !full;
  assign rd_ok = rd_en && !empty;

  // Pointers
  always_ff @(posedge clk100M) begin
    if (rst_command || run_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_ok)
        wr_ptr <= wr_ptr + 1'b1;
      if (rd_ok)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // Storage and registered read
  always_ff @(posedge clk100M) begin
    if (wr_ok)
      mem[wr_ptr[AW-1:0]] <= wr_data;
    if (rd_ok)
      rd_data <= mem[rd_ptr[AW-1:0]];
  end

  // Host must check empty before reading
  a_no_read_empty: assert property (
    @(posedge clk100M) disable iff (rst_command) rd_en |-> !empty
  );

endmodule

//--- adc_readout_top.sv
`timescale 1ns/1ns

module adc_readout_top (
  input  logic                 clk100M,
  input  logic                 rst_command,
  // Host mailbox port
  input  host_pkg::mbox_addr_t host_mem_addr,
  input  logic                 host_mem_wr_en,
  input  host_pkg::mbox_byte_t host_mem_wdata,
  input  logic                 host_mem_rd_en,
  output host_pkg::mbox_byte_t host_mem_rdata,
  // Parallel ADC samples
  input  logic                 sample_strobe,
  input  acq_pkg::adc_sample_t ch0,
  input  acq_pkg::adc_sample_t ch1,
  input  acq_pkg::adc_sample_t ch2,
  input  acq_pkg::adc_sample_t ch3,
  input  logic                 frame_mark,
  // Host event read port
  input  logic                 host_rd_en,
  output acq_pkg::fifo_word_t  host_rd_data,
  output logic                 host_rd_empty,
  output logic                 write_veto
);

  host_pkg::mbox_addr_t mbox_b_addr;
  logic                 mbox_b_wr_en;
  host_pkg::mbox_byte_t mbox_b_wdata;
  host_pkg::mbox_byte_t mbox_b_rdata;
  logic                 run_reset;   // Flushes packer and FIFO
  logic                 fifo_full;
  logic                 word_valid;
  acq_pkg::fifo_word_t  word_data;

  mailbox_ram u_mailbox_ram (
    .clk100M (clk100M),
    .a_addr  (host_mem_addr),
    .a_wr_en (host_mem_wr_en),
    .a_wdata (host_mem_wdata),
    .a_rd_en (host_mem_rd_en),
    .a_rdata (host_mem_rdata),
    .b_addr  (mbox_b_addr),
    .b_wr_en (mbox_b_wr_en),
    .b_wdata (mbox_b_wdata),
    .b_rdata (mbox_b_rdata)
  );

  acq_control u_acq_control (
    .clk100M     (clk100M),
    .rst_command (rst_command),
    .mbox_rdata  (mbox_b_rdata),
    .fifo_full   (fifo_full),
    .mbox_addr   (mbox_b_addr),
    .mbox_wr_en  (mbox_b_wr_en),
    .mbox_wdata  (mbox_b_wdata),
    .run_reset   (run_reset),
    .write_veto  (write_veto)
  );

  frame_packer u_frame_packer (
    .clk100M       (clk100M),
    .rst_command   (rst_command),
    .run_reset     (run_reset),
    .sample_strobe (sample_strobe),
    .ch0           (ch0),
    .ch1           (ch1),
    .ch2           (ch2),
    .ch3           (ch3),
    .frame_mark    (frame_mark),
    .word_valid    (word_valid),
    .word_data     (word_data)
  );

  event_fifo u_event_fifo (
    .clk100M     (clk100M),
    .rst_command (rst_command),
    .run_reset   (run_reset),
    .wr_en       (word_valid),
    .wr_data     (word_data),
    .write_veto  (write_veto),
    .rd_en       (host_rd_en),
    .rd_data     (host_rd_data),
    .empty       (host_rd_empty),
    .full        (fifo_full)
  );

endmodule

//--- tb_checker.sv
`timescale 1ns/1ns
`include "daq_consts.svh"

module tb_checker (
  input  logic               clk100M,
  input  logic               rst_command,
  input  logic               host_mem_rd_en,
  input  logic [7:0]         host_mem_rdata,
  input  logic               host_rd_en,
  input  logic               host_rd_empty,
  input  logic [`WORD_W-1:0] host_rd_data,
  input  logic               write_veto,
  input  logic               word_push,    // Expected word from the stimulus
  input  logic [`WORD_W-1:0] word_exp,
  input  logic               byte_push,    // Marks a mailbox read worth checking
  input  logic [7:0]         byte_exp,
  input  logic               flag_chk,
  input  logic               flag_sel,     // 0 veto, 1 empty
  input  logic               flag_exp,
  output int                 chk_errors,
  output int                 chk_pending   // Words still owed by the FIFO
);

  logic [`WORD_W-1:0] exp_q [$];
  logic [`WORD_W-1:0] exp_w;
  logic               rd_pend;   // FIFO data lands this cycle
  logic               mem_pend;  // Mailbox data lands this cycle
  logic [7:0]         mem_exp;
  logic               flag_got;

  // Values seen here are the ones just before the edge
  always @(posedge clk100M) begin
    if (rst_command) begin
      rd_pend  <= 1'b0;
      mem_pend <= 1'b0;
      exp_q.delete();
    end else begin
      if (word_push)
        exp_q.push_back(word_exp);
      if (rd_pend) begin
        if (exp_q.size() == 0) begin
          $display("word %h came out of the FIFO with nothing expected", host_rd_data);
          chk_errors++;
        end else begin
          exp_w = exp_q.pop_front();  // Oldest word first
          if (host_rd_data !== exp_w) begin
            $display("error host_rd_data exp %h got %h", exp_w, host_rd_data);
            chk_errors++;
          end
        end
      end
      if (mem_pend && host_mem_rdata !== mem_exp) begin
        $display("error host_mem_rdata exp %h got %h", mem_exp, host_mem_rdata);
        chk_errors++;
      end
      if (flag_chk) begin
        flag_got = flag_sel ? host_rd_empty : write_veto;
        if (flag_got !== flag_exp) begin
          if (flag_sel)
            $display("error host_rd_empty exp %h got %h", flag_exp, flag_got);
          else
            $display("error write_veto exp %h got %h", flag_exp, flag_got);
          chk_errors++;
        end
      end
      rd_pend  <= host_rd_en && !host_rd_empty;  // Read data is registered
      mem_pend <= host_mem_rd_en && byte_push;
      mem_exp  <= byte_exp;
    end
    chk_pending = exp_q.size();
  end

endmodule

//--- tb_adc_readout.sv
`timescale 1ns/1ns
`include "daq_consts.svh"

module tb_adc_readout;

  localparam bit SEL_VETO  = 1'b0;
  localparam bit SEL_EMPTY = 1'b1;

  logic                 clk100M;
  logic                 rst_command;
  logic [`MBOX_AW-1:0]  host_mem_addr;
  logic                 host_mem_wr_en;
  logic [7:0]           host_mem_wdata;
  logic                 host_mem_rd_en;
  logic [7:0]           host_mem_rdata;
  logic                 sample_strobe;
  logic [`SAMPLE_W-1:0] ch0, ch1, ch2, ch3;
  logic                 frame_mark;
  logic                 host_rd_en;
  logic [`WORD_W-1:0]   host_rd_data;
  logic                 host_rd_empty;
  logic                 write_veto;
  logic                 word_push;    // Expectations toward the checker
  logic [`WORD_W-1:0]   word_exp;
  logic                 byte_push;
  logic [7:0]           byte_exp;
  logic                 flag_chk;
  logic                 flag_sel;
  logic                 flag_exp;
  int                   chk_errors;
  int                   chk_pending;
  integer               seed;
  int                   frame_cnt;    // Falling edges since last reset
  int                   tb_errs;      // Timeouts and count mismatches
  int                   err_mark;
  int                   tests;
  int                   fails;
  int                   nread;
  logic [7:0]           mem_img [0:`MBOX_DEPTH-1];

  adc_readout_top u_adc_readout_top (.*);
  tb_checker u_checker (.*);

  initial begin
    clk100M = 1'b0;
    forever #5 clk100M = ~clk100M;  // 100 MHz
  end

  // Reference model of the packer output
  // Kind 0 is a channel pair, kind 1 a trailer with the frame count in lo
  function automatic logic [`WORD_W-1:0] expected_word(input int kind,
      input logic [15:0] lo, input logic [15:0] hi);
    if (kind == 1)
      expected_word = {`TRAILER_TAG, lo};
    else
      expected_word = {hi, lo};
  endfunction

  task automatic mem_write(input int addr, input logic [7:0] data);
    @(negedge clk100M);
    host_mem_addr  = addr;
    host_mem_wdata = data;
    host_mem_wr_en = 1'b1;
    @(negedge clk100M);
    host_mem_wr_en = 1'b0;
  endtask

  task automatic mem_read_check(input int addr, input logic [7:0] exp);
    @(negedge clk100M);
    host_mem_addr  = addr;
    host_mem_rd_en = 1'b1;
    byte_push      = 1'b1;
    byte_exp       = exp;
    @(negedge clk100M);
    host_mem_rd_en = 1'b0;
    byte_push      = 1'b0;
  endtask

  // Poll byte 0 until the acknowledge shows up
  task automatic poll_ack(input logic [7:0] exp);
    int n;
    logic [7:0] got;
    n   = 0;
    got = 8'h00;
    while (got !== exp && n < 50) begin
      @(negedge clk100M);
      host_mem_addr  = `CMD_ADDR;
      host_mem_rd_en = 1'b1;
      @(negedge clk100M);
      host_mem_rd_en = 1'b0;
      got = host_mem_rdata;  // Valid one cycle after rd_en
      n++;
    end
    if (got !== exp) begin
      $display("command byte never showed acknowledge %h", exp);
      tb_errs++;
    end
    mem_read_check(`CMD_ADDR, exp);
  endtask

  task automatic flag_check(input logic sel, input logic exp);
    @(negedge clk100M);
    flag_chk = 1'b1;
    flag_sel = sel;
    flag_exp = exp;
    @(negedge clk100M);
    flag_chk = 1'b0;
  endtask

  task automatic wait_veto(input logic level, input int limit);
    int n;
    n = 0;
    while (write_veto !== level && n < limit) begin
      @(negedge clk100M);
      n++;
    end
    if (write_veto !== level) begin
      $display("write_veto did not reach %0d within %0d cycles", level, limit);
      tb_errs++;
    end
  endtask

  // Three cycles per strobe, the minimum spacing
  task automatic send_pair(input logic keep);
    @(negedge clk100M);
    ch0 = $random(seed);
    ch1 = $random(seed);
    ch2 = $random(seed);
    ch3 = $random(seed);
    sample_strobe = 1'b1;
    word_push     = keep;
    word_exp      = expected_word(0, ch0, ch1);
    @(negedge clk100M);
    sample_strobe = 1'b0;
    word_exp      = expected_word(0, ch2, ch3);
    @(negedge clk100M);
    word_push = 1'b0;
  endtask

  task automatic frame_end(input logic keep);
    @(negedge clk100M);
    frame_mark = 1'b1;
    @(negedge clk100M);
    frame_mark = 1'b0;  // Falling edge queues a trailer
    frame_cnt++;
    word_push = keep;
    word_exp  = expected_word(1, frame_cnt[15:0], 16'h0000);
    @(negedge clk100M);
    word_push = 1'b0;
  endtask

  task automatic drain_all(output int count);
    count = 0;
    repeat (4) @(negedge clk100M);  // Packer done
    while (!host_rd_empty && count < 64) begin
      host_rd_en = 1'b1;
      @(negedge clk100M);
      count++;
    end
    host_rd_en = 1'b0;
    if (!host_rd_empty) begin
      $display("FIFO still held words after %0d reads", count);
      tb_errs++;
    end
    repeat (2) @(negedge clk100M);  // Last compare lands
  endtask

  task automatic check_drained();
    if (chk_pending != 0) begin
      $display("%0d expected words never came out of the FIFO", chk_pending);
      tb_errs++;
    end
  endtask

  task automatic end_test(input string name);
    int errs;
    errs     = tb_errs + chk_errors - err_mark;
    err_mark = tb_errs + chk_errors;
    tests++;
    if (errs == 0) begin
      $display("test %0d %s ok", tests, name);
    end else begin
      fails++;
      $display("test %0d %s failed with %0d errors", tests, name, errs);
    end
  endtask

  initial begin
    seed           = 72;
    rst_command    = 1'b1;
    host_mem_addr  = '0;
    host_mem_wr_en = 1'b0;
    host_mem_wdata = 8'h00;
    host_mem_rd_en = 1'b0;
    sample_strobe  = 1'b0;
    ch0            = '0;
    ch1            = '0;
    ch2            = '0;
    ch3            = '0;
    frame_mark     = 1'b0;
    host_rd_en     = 1'b0;
    word_push      = 1'b0;
    word_exp       = '0;
    byte_push      = 1'b0;
    byte_exp       = 8'h00;
    flag_chk       = 1'b0;
    flag_sel       = SEL_VETO;
    flag_exp       = 1'b0;
    frame_cnt      = 0;
    tb_errs        = 0;
    err_mark       = 0;
    tests          = 0;
    fails          = 0;
    repeat (10) @(negedge clk100M);
    rst_command = 1'b0;

    flag_check(SEL_VETO, 1'b1);
    flag_check(SEL_EMPTY, 1'b1);
    wait_veto(1'b0, 1000);  // 451 cycles of settling
    end_test("reset and settling");

    for (int a = 2; a < `MBOX_DEPTH; a++) begin
      mem_img[a] = $random(seed);
      mem_write(a, mem_img[a]);
    end
    for (int a = 2; a < `MBOX_DEPTH; a++)
      mem_read_check(a, mem_img[a]);
    end_test("mailbox");

    repeat (4) send_pair(1'b1);
    drain_all(nread);
    check_drained();
    end_test("sample packing");

    repeat (3) begin
      send_pair(1'b1);
      send_pair(1'b1);
      frame_end(1'b1);
    end
    drain_all(nread);
    check_drained();
    end_test("frame trailers");

    send_pair(1'b0);  // Left in the FIFO for the flush
    mem_write(`CMD_ADDR, 8'h01);
    poll_ack(8'h81);
    flag_check(SEL_VETO, 1'b1);
    flag_check(SEL_EMPTY, 1'b1);
    frame_cnt = 0;
    wait_veto(1'b0, 1000);
    frame_end(1'b1);  // Count restarts at 1
    send_pair(1'b1);
    drain_all(nread);
    check_drained();
    end_test("reset command");

    mem_write(`CMD_ADDR, 8'h02);
    poll_ack(8'h82);
    flag_check(SEL_VETO, 1'b1);
    send_pair(1'b0);
    send_pair(1'b0);
    frame_end(1'b0);
    repeat (4) @(negedge clk100M);
    flag_check(SEL_EMPTY, 1'b1);  // Nothing got through
    flag_check(SEL_VETO, 1'b1);
    mem_write(`CMD_ADDR, 8'h01);  // Restart for the next test
    poll_ack(8'h81);
    frame_cnt = 0;
    wait_veto(1'b0, 1000);
    end_test("stop command");

    // Only the first FIFO_DEPTH words fit
    for (int p = 0; p < 10; p++)
      send_pair(p < `FIFO_DEPTH / 2);
    repeat (4) @(negedge clk100M);
    flag_check(SEL_VETO, 1'b1);
    repeat (20) @(negedge clk100M);
    flag_check(SEL_VETO, 1'b1);  // Sticky
    drain_all(nread);
    if (nread != `FIFO_DEPTH) begin
      $display("error read_count exp %h got %h", `FIFO_DEPTH, nread);
      tb_errs++;
    end
    flag_check(SEL_EMPTY, 1'b1);
    check_drained();
    end_test("overflow");

    $display("tests %0d failed %0d errors %0d", tests, fails, tb_errs + chk_errors);
    if (fails == 0 && tb_errs + chk_errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

endmodule

//--- sim.f
+incdir+.
acq_pkg.sv
host_pkg.sv
mailbox_ram.sv
acq_control.sv
frame_packer.sv
event_fifo.sv
adc_readout_top.sv
tb_checker.sv
tb_adc_readout.sv
